//--- hdl/exec_pkg.sv
/* execute stage shared definitions */

package exec_pkg;

   // datapath width, fixed by the four shifter stages (1, 2, 4, 8)
   localparam int data_w = 16;

   // shift count width, covers amounts 0 to 15
   localparam int cnt_w = 4;

   // operations accepted by the execute stage
   typedef enum logic [2:0] {
      // a plus b, wraps
      add_op = 3'd0,
      // a minus b, wraps
      sub_op = 3'd1,
      // bitwise and
      and_op = 3'd2,
      // bitwise exclusive or
      xor_op = 3'd3,
      // rotate left
      rol_op = 3'd4,
      // shift left, zero fill
      sll_op = 3'd5,
      // rotate right
      ror_op = 3'd6,
      // shift right, zero fill
      srl_op = 3'd7
   } alu_op_e;

   // shifter mode select, rol 00, sll 01, ror 10, srl 11
   typedef enum logic [1:0] {
      shift_rol = 2'b00,
      shift_sll = 2'b01,
      shift_ror = 2'b10,
      shift_srl = 2'b11
   } shift_op_e;

endpackage

//--- hdl/shifter.sv
/* logarithmic barrel shifter */

module shifter (
   input  logic [exec_pkg::data_w-1:0] in_data,
   input  logic [exec_pkg::cnt_w-1:0]  cnt,
   input  exec_pkg::shift_op_e         shift_op,
   output logic [exec_pkg::data_w-1:0] out_data
);

   import exec_pkg::*;

   // stage_data[0] is the input, stage_data[cnt_w] the final result
   logic [data_w-1:0] stage_data [0:cnt_w];

   // one stage of the cascade, amt is a constant per stage
   function automatic logic [data_w-1:0] shift_by(
      input logic [data_w-1:0] din,
      input shift_op_e         sop,
      input int                amt
   );
      logic [data_w-1:0] res;
      case (sop)
         // bits leaving the top come back in at the bottom
         shift_rol: res = (din << amt) | (din >> (data_w - amt));
         shift_sll: res = din << amt;
         // bits leaving the bottom come back in at the top
         shift_ror: res = (din >> amt) | (din << (data_w - amt));
         shift_srl: res = din >> amt;
         default:   res = din;
      endcase
      return res;
   endfunction

   assign stage_data[0] = in_data;

   // four stages of 1, 2, 4 and 8 bits
   for (genvar i = 0; i < cnt_w; i++) begin : g_stage
      localparam int amt = 1 << i;

      // count bit i decides whether this stage moves the data
      assign stage_data[i+1] = cnt[i] ? shift_by(stage_data[i], shift_op, amt)
                                      : stage_data[i];
   end

   assign out_data = stage_data[cnt_w];

endmodule

//--- hdl/alu_core.sv
/* execute stage arithmetic and logic unit */

module alu_core (
   input  exec_pkg::alu_op_e           d_op,
   input  logic [exec_pkg::data_w-1:0] d_a,
   input  logic [exec_pkg::data_w-1:0] d_b,
   input  exec_pkg::shift_op_e         d_shift_op,
   input  logic [exec_pkg::cnt_w-1:0]  d_cnt,
   output logic [exec_pkg::data_w-1:0] alu_result,
   output logic                        alu_ovf
);

   import exec_pkg::*;

   logic [data_w-1:0] sum;
   logic [data_w-1:0] diff;
   logic [data_w-1:0] shift_out;
   logic              sum_ovf;
   logic              diff_ovf;

   // both arithmetic results are formed every cycle, d_op picks one
   assign sum  = d_a + d_b;
   assign diff = d_a - d_b;

   // add overflows when like signs give a result of the other sign
   assign sum_ovf = (d_a[data_w-1] == d_b[data_w-1]) &&
                    (sum[data_w-1] != d_a[data_w-1]);

   // subtract overflows when unlike signs flip the sign of a
   assign diff_ovf = (d_a[data_w-1] != d_b[data_w-1]) &&
                     (diff[data_w-1] != d_a[data_w-1]);

   // rotates and logical shifts, count and mode already chosen by decode
   shifter u_shifter (
      .in_data  (d_a),
      .cnt      (d_cnt),
      .shift_op (d_shift_op),
      .out_data (shift_out)
   );

   // result select
   always_comb begin
      alu_result = '0;
      alu_ovf    = 1'b0;
      case (d_op)
         add_op: begin
            alu_result = sum;
            alu_ovf    = sum_ovf;
         end
         sub_op: begin
            alu_result = diff;
            alu_ovf    = diff_ovf;
         end
         and_op: alu_result = d_a & d_b;
         xor_op: alu_result = d_a ^ d_b;
         // all four shift flavors share the one shifter
         rol_op,
         sll_op,
         ror_op,
         srl_op: alu_result = shift_out;
         default: begin
            alu_result = '0;
            alu_ovf    = 1'b0;
         end
      endcase
   end

endmodule

//--- hdl/exec_decode.sv
/* execute stage operand latch and decode */

module exec_decode (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  exec_pkg::alu_op_e           op,
   input  logic [exec_pkg::data_w-1:0] a,
   input  logic [exec_pkg::data_w-1:0] b,
   input  logic [exec_pkg::cnt_w-1:0]  imm,
   input  logic                        use_imm,
   output logic                        d_valid,
   output exec_pkg::alu_op_e           d_op,
   output logic [exec_pkg::data_w-1:0] d_a,
   output logic [exec_pkg::data_w-1:0] d_b,
   output exec_pkg::shift_op_e         d_shift_op,
   output logic [exec_pkg::cnt_w-1:0]  d_cnt
);

   import exec_pkg::*;

   shift_op_e         shift_sel;
   logic [cnt_w-1:0]  cnt_sel;

   // map the shift operations onto the shifter mode code
   always_comb begin
      case (op)
         rol_op:  shift_sel = shift_rol;
         sll_op:  shift_sel = shift_sll;
         ror_op:  shift_sel = shift_ror;
         srl_op:  shift_sel = shift_srl;
         // don't care for add, sub and logic ops
         default: shift_sel = shift_rol;
      endcase
   end

   // shift amount from the immediate or from the low bits of b
   assign cnt_sel = use_imm ? imm : b[cnt_w-1:0];

   // valid follows the strobe every cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         d_valid <= 1'b0;
      end else begin
         d_valid <= in_valid;
      end
   end

   // operands and decoded fields only load on a strobe
   always_ff @(posedge clk) begin
      if (in_valid) begin
         d_op       <= op;
         d_a        <= a;
         d_b        <= b;
         d_shift_op <= shift_sel;
         d_cnt      <= cnt_sel;
      end
   end

   // a strobed operation must carry a defined opcode
   a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> !$isunknown(op));

endmodule

//--- hdl/result_stage.sv
/* execute stage result register and flags */

module result_stage (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        d_valid,
   input  logic [exec_pkg::data_w-1:0] alu_result,
   input  logic                        alu_ovf,
   output logic                        out_valid,
   output logic [exec_pkg::data_w-1:0] result,
   output logic                        zero,
   output logic                        neg,
   output logic                        ovf
);

   import exec_pkg::*;

   // out_valid is a one cycle pulse per decoded operation
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= d_valid;
      end
   end

   // result and flags hold until the next valid operation
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result <= '0;
         zero   <= 1'b0;
         neg    <= 1'b0;
         ovf    <= 1'b0;
      end else if (d_valid) begin
         result <= alu_result;
         // flags come from the same alu value as the result
         zero   <= (alu_result == '0);
         neg    <= alu_result[data_w-1];
         ovf    <= alu_ovf;
      end
   end

   // nothing comes out in the first cycle after reset is released
   a_quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |=> !out_valid);

   // a reported result is always fully defined
   a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> !$isunknown(result));

endmodule

//--- hdl/exec_unit.sv
/* execute stage top level */

module exec_unit (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  exec_pkg::alu_op_e           op,
   input  logic [exec_pkg::data_w-1:0] a,
   input  logic [exec_pkg::data_w-1:0] b,
   input  logic [exec_pkg::cnt_w-1:0]  imm,
   input  logic                        use_imm,
   output logic                        out_valid,
   output logic [exec_pkg::data_w-1:0] result,
   output logic                        zero,
   output logic                        neg,
   output logic                        ovf
);

   import exec_pkg::*;

   // decode to alu
   logic              d_valid;
   alu_op_e           d_op;
   logic [data_w-1:0] d_a;
   logic [data_w-1:0] d_b;
   shift_op_e         d_shift_op;
   logic [cnt_w-1:0]  d_cnt;

   // alu to result register
   logic [data_w-1:0] alu_result;
   logic              alu_ovf;

   // first cycle, latch and decode
   exec_decode u_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .op         (op),
      .a          (a),
      .b          (b),
      .imm        (imm),
      .use_imm    (use_imm),
      .d_valid    (d_valid),
      .d_op       (d_op),
      .d_a        (d_a),
      .d_b        (d_b),
      .d_shift_op (d_shift_op),
      .d_cnt      (d_cnt)
   );

   alu_core u_alu (
      .d_op       (d_op),
      .d_a        (d_a),
      .d_b        (d_b),
      .d_shift_op (d_shift_op),
      .d_cnt      (d_cnt),
      .alu_result (alu_result),
      .alu_ovf    (alu_ovf)
   );

   // second cycle, result and flags
   result_stage u_result (
      .clk        (clk),
      .rst_n      (rst_n),
      .d_valid    (d_valid),
      .alu_result (alu_result),
      .alu_ovf    (alu_ovf),
      .out_valid  (out_valid),
      .result     (result),
      .zero       (zero),
      .neg        (neg),
      .ovf        (ovf)
   );

endmodule

//--- dv/exec_unit_tb.sv
/* execute stage testbench */

module exec_unit_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import exec_pkg::*;

   localparam int n_vec       = 40;
   localparam int latency     = 2;
   localparam int drain_limit = 20;

   logic              clk;
   logic              rst_n;
   logic              in_valid;
   alu_op_e           op;
   logic [data_w-1:0] a;
   logic [data_w-1:0] b;
   logic [cnt_w-1:0]  imm;
   logic              use_imm;
   logic              out_valid;
   logic [data_w-1:0] result;
   logic              zero;
   logic              neg;
   logic              ovf;

   // one packed vector per line of the data file
   logic [63:0] vec_mem [0:n_vec-1];
   // vector index and drive cycle of each operation in flight
   int idx_q [$];
   int cyc_q [$];
   int cycle;
   int checked;

   exec_unit DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                  input logic [15:0] act_v);
      report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
   endtask

   // compare one finished operation against the front of the queue
   task automatic check_outputs();
      int          idx;
      int          start;
      logic [63:0] v;
      string       name;
      if (out_valid) begin
         assert (idx_q.size() > 0)
            else report_failure("out_valid was raised with no operation in flight");
         idx   = idx_q.pop_front();
         start = cyc_q.pop_front();
         v     = vec_mem[idx];
         name  = $sformatf("vector %0d", idx);
         assert (cycle - start == latency)
            else report_mismatch({name, " latency"}, 16'(latency), 16'(cycle - start));
         assert (result === v[19:4]) else report_mismatch({name, " result"}, v[19:4], result);
         // flag nibble is {0, zero, neg, ovf}
         assert (zero === v[2]) else report_mismatch({name, " zero"}, 16'(v[2]), 16'(zero));
         assert (neg === v[1]) else report_mismatch({name, " neg"}, 16'(v[1]), 16'(neg));
         assert (ovf === v[0]) else report_mismatch({name, " ovf"}, 16'(v[0]), 16'(ovf));
         checked++;
      end
   endtask

   // outputs settle at the rising edge, so look at them on the falling one
   task automatic step();
      @(negedge clk);
      cycle++;
      check_outputs();
   endtask

   task automatic drive_vector(input int idx);
      logic [63:0] v;
      v        = vec_mem[idx];
      op       = alu_op_e'(v[62:60]);
      a        = v[59:44];
      b        = v[43:28];
      imm      = v[27:24];
      use_imm  = v[20];
      in_valid = 1'b1;
      idx_q.push_back(idx);
      cyc_q.push_back(cycle);
   endtask

   initial begin
      int seed;
      int gap;
      int wait_cnt;
      seed     = 34;
      cycle    = 0;
      checked  = 0;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      op       = add_op;
      a        = '0;
      b        = '0;
      imm      = '0;
      use_imm  = 1'b0;
      $readmemh("dv/exec_testdata.txt", vec_mem);
      assert (!$isunknown(vec_mem[n_vec-1]))
         else report_failure("test data file is missing or too short");
      // outputs stay quiet through reset and a few idle cycles after it
      repeat (12) begin
         step();
         if (cycle == 8) rst_n = 1'b1;
         assert (!out_valid && result == '0)
            else report_failure("outputs active while idle around reset");
      end
      // first half back to back, second half with random idle gaps
      for (int i = 0; i < n_vec; i++) begin
         drive_vector(i);
         step();
         if (i >= n_vec / 2) begin
            gap = $unsigned($random(seed)) % 4;
            if (gap > 0) begin
               in_valid = 1'b0;
               repeat (gap) step();
            end
         end
      end
      in_valid = 1'b0;
      wait_cnt = 0;
      while (idx_q.size() > 0 && wait_cnt < drain_limit) begin
         step();
         wait_cnt++;
      end
      assert (idx_q.size() == 0) else report_failure("timed out waiting for out_valid");
      // no stray output once the pipeline is empty
      repeat (3) step();
      if (checked == n_vec) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         report_failure($sformatf("only %0d of %0d results were checked", checked, n_vec));
      end
   end

endmodule

//--- dv/exec_testdata.txt
// op _ a _ b _ imm _ use_imm _ expected result _ flags {0, zero, neg, ovf}
// op: 0 add, 1 sub, 2 and, 3 xor, 4 rol, 5 sll, 6 ror, 7 srl
0_0001_0002_0_0_0003_0
0_7fff_0001_0_0_8000_3
0_ffff_0001_0_0_0000_4
0_8000_8000_0_0_0000_5
1_8000_0001_0_0_7fff_1
1_0005_0007_0_0_fffe_2
1_1234_1234_0_0_0000_4
1_7fff_ffff_0_0_8000_3
2_f0f0_ff00_0_0_f000_2
2_00ff_ff00_0_0_0000_4
3_aaaa_5555_0_0_ffff_2
3_1234_0ff0_0_0_1dc4_0
4_8001_000f_1_1_0003_0
4_1234_0004_f_0_2341_0
4_1234_0000_8_1_3412_0
4_8001_abcf_0_0_c000_2
4_ffff_0000_7_1_ffff_2
4_1234_0000_0_1_1234_0
4_abcd_0000_2_1_af36_2
4_0001_0009_0_0_0200_0
5_1234_0000_4_1_2340_0
5_ffff_0008_0_0_ff00_2
5_ffff_0000_f_1_8000_2
5_00ff_000c_0_0_f000_2
5_0001_0000_3_1_0008_0
5_8000_0000_1_1_0000_4
5_0001_0000_b_1_0800_0
6_0003_0000_1_1_8001_2
6_1234_0004_0_0_4123_0
6_1234_0000_8_1_3412_0
6_8001_000f_0_0_0003_0
6_ffff_0000_5_1_ffff_2
6_abcd_0000_2_1_6af3_0
6_0001_000d_0_0_0008_0
7_8000_0000_f_1_0001_0
7_ffff_0008_0_0_00ff_0
7_ffff_0000_e_1_0003_0
7_0001_0000_1_1_0000_4
7_abcd_0006_0_0_02af_0
7_8000_000a_0_0_0020_0

//--- src.f
hdl/exec_pkg.sv
hdl/shifter.sv
hdl/alu_core.sv
hdl/exec_decode.sv
hdl/result_stage.sv
hdl/exec_unit.sv
dv/exec_unit_tb.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := exec_unit_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))
DATA     := dv/exec_testdata.txt

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
